// File: bench/dcacheTb.sv
`timescale 1ns/1ps

module dcacheTb;
  import dcachePkg::*;

  localparam int    NUM_ROWS     = 17;
  localparam int    RESET_CYCLES = 8;
  localparam word_t PATTERN      = 64'h5a5a_c3c3_0ff0_a55a;

  typedef struct packed {
    cacheOp_e op;
    addr_t    addr;
    word_t    data;
    mask_t    mask;
    logic     expMiss;
    logic     expWb;
    addr_t    wbAddr;
  } stimRow_t;

  logic      clk;
  logic      rst_n;
  logic      reqValid;
  logic      addrOk;
  logic      respValid;
  logic      rdValid;
  logic      wrValid;
  logic      memRdReady;
  logic      memDataValid;
  logic      memLast;
  logic      memWrReady;
  cacheReq_t req;
  word_t     rdData;
  word_t     memData;
  addr_t     rdAddr;
  addr_t     wrAddr;
  addr_t     lastWrAddr;
  line_t     wrData;
  line_t     lastWrData;
  int        rdCount;
  int        wrCount;
  int        errors;
  int        checks;
  int        expWrites;
  stimRow_t  stim [NUM_ROWS];
  logic [7:0] shadow [addr_t];

  dcacheTop #(.SETS(64)) DUT (
    .clk(clk), .rst_n(rst_n), .req_i(req), .reqValid_i(reqValid),
    .addrOk_o(addrOk), .respValid_o(respValid), .rdData_o(rdData),
    .rdValid_o(rdValid), .rdAddr_o(rdAddr), .memRdReady_i(memRdReady),
    .memData_i(memData), .memDataValid_i(memDataValid), .memLast_i(memLast),
    .wrValid_o(wrValid), .wrAddr_o(wrAddr), .wrData_o(wrData),
    .memWrReady_i(memWrReady)
  );

  memModel #(.PATTERN(PATTERN), .SEED(32'h393b_0a0c)) uMem (
    .clk(clk), .rdValid_i(rdValid), .rdAddr_i(rdAddr), .rdReady_o(memRdReady),
    .data_o(memData), .dataValid_o(memDataValid), .last_o(memLast),
    .wrValid_i(wrValid), .wrAddr_i(wrAddr), .wrData_i(wrData),
    .wrReady_o(memWrReady), .rdCount_o(rdCount), .wrCount_o(wrCount),
    .lastWrAddr_o(lastWrAddr), .lastWrData_o(lastWrData)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // untouched bytes follow the memory fill rule
  function automatic logic [7:0] shadowByte(addr_t a);
    addr_t base;
    word_t w;
    if (shadow.exists(a)) begin
      return shadow[a];
    end
    base = {a[ADDR_WIDTH-1:3], 3'b000};
    w    = {base, base} ^ PATTERN;
    return w[a[2:0]*8 +: 8];
  endfunction

  function automatic word_t shadowWord(addr_t a);
    word_t w;
    for (int i = 0; i < 8; i++) begin
      w[i*8 +: 8] = shadowByte(a + addr_t'(i));
    end
    return w;
  endfunction

  function automatic line_t shadowLine(addr_t a);
    line_t l;
    for (int w = 0; w < WORDS_PER_LINE; w++) begin
      l[w] = shadowWord(a + addr_t'(w * 8));
    end
    return l;
  endfunction

  task automatic storeShadow(addr_t a, word_t d, mask_t m);
    addr_t base;
    base = {a[ADDR_WIDTH-1:3], 3'b000};
    for (int i = 0; i < 8; i++) begin
      if (m[i]) begin
        shadow[base + addr_t'(i)] = d[i*8 +: 8];
      end
    end
  endtask

  task automatic reportMismatch(string name, logic [255:0] expVal, logic [255:0] gotVal);
    errors++;
    $display("MISMATCH time=%0t signal=%s expected=%0h got=%0h", $time, name, expVal, gotVal);
  endtask

  task automatic setRow(int i, cacheOp_e op, addr_t a, word_t d, mask_t m,
                        logic miss, logic wb, addr_t wa);
    stim[i] = '{op, a, d, m, miss, wb, wa};
  endtask

  // set 8 lines 0x1100, 0x1900, 0x2100, 0x2900 exercise replacement
  task automatic buildTable();
    setRow(0,  OP_LOAD,  32'h0000_1108, 64'h0, 8'h00, 1'b1, 1'b0, 32'h0);
    setRow(1,  OP_LOAD,  32'h0000_1110, 64'h0, 8'h00, 1'b0, 1'b0, 32'h0);
    setRow(2,  OP_STORE, 32'h0000_1118, 64'h1122_3344_5566_7788, 8'h0f, 1'b0, 1'b0, 32'h0);
    setRow(3,  OP_LOAD,  32'h0000_1118, 64'h0, 8'h00, 1'b0, 1'b0, 32'h0);
    setRow(4,  OP_LOAD,  32'h0000_1900, 64'h0, 8'h00, 1'b1, 1'b0, 32'h0);
    setRow(5,  OP_LOAD,  32'h0000_2108, 64'h0, 8'h00, 1'b1, 1'b1, 32'h0000_1100);
    setRow(6,  OP_LOAD,  32'h0000_1118, 64'h0, 8'h00, 1'b1, 1'b0, 32'h0);
    setRow(7,  OP_STORE, 32'h0000_2110, 64'hdead_beef_0bad_f00d, 8'hf0, 1'b0, 1'b0, 32'h0);
    setRow(8,  OP_STORE, 32'h0000_2110, 64'hcafe_f00d_1234_abcd, 8'h3c, 1'b0, 1'b0, 32'h0);
    setRow(9,  OP_LOAD,  32'h0000_2110, 64'h0, 8'h00, 1'b0, 1'b0, 32'h0);
    setRow(10, OP_LOAD,  32'h0000_4020, 64'h0, 8'h00, 1'b1, 1'b0, 32'h0);
    setRow(11, OP_STORE, 32'h0000_4038, 64'h0123_4567_89ab_cdef, 8'hff, 1'b0, 1'b0, 32'h0);
    setRow(12, OP_LOAD,  32'h0000_4038, 64'h0, 8'h00, 1'b0, 1'b0, 32'h0);
    setRow(13, OP_STORE, 32'h0000_6000, 64'h8877_6655_4433_2211, 8'h81, 1'b1, 1'b0, 32'h0);
    setRow(14, OP_LOAD,  32'h0000_6000, 64'h0, 8'h00, 1'b0, 1'b0, 32'h0);
    setRow(15, OP_LOAD,  32'h0000_2900, 64'h0, 8'h00, 1'b1, 1'b1, 32'h0000_2100);
    setRow(16, OP_LOAD,  32'h0000_2110, 64'h0, 8'h00, 1'b1, 1'b0, 32'h0);
  endtask

  task automatic checkIdle();
    checks++;
    if (respValid !== 1'b0) reportMismatch("respValid_o", 256'(1'b0), 256'(respValid));
    if (rdValid !== 1'b0) reportMismatch("rdValid_o", 256'(1'b0), 256'(rdValid));
    if (wrValid !== 1'b0) reportMismatch("wrValid_o", 256'(1'b0), 256'(wrValid));
    if (addrOk !== 1'b1) reportMismatch("addrOk_o", 256'(1'b1), 256'(addrOk));
  endtask

  task automatic runRow(int i);
    stimRow_t r;
    int       rdBefore;
    int       wrBefore;
    word_t    expWord;
    r = stim[i];
    while (!addrOk) @(negedge clk);
    rdBefore = rdCount;
    wrBefore = wrCount;
    req      = '{r.op, r.addr, r.data, r.mask};
    reqValid = 1'b1;
    @(negedge clk);
    reqValid = 1'b0;
    while (!respValid) @(negedge clk);
    checks++;
    if (r.op == OP_LOAD) begin
      expWord = shadowWord({r.addr[ADDR_WIDTH-1:3], 3'b000});
      if (rdData !== expWord) reportMismatch("rdData_o", 256'(expWord), 256'(rdData));
    end
    if (rdCount - rdBefore != int'(r.expMiss)) begin
      reportMismatch("line reads", 256'(r.expMiss), 256'(rdCount - rdBefore));
    end
    if (wrCount - wrBefore != int'(r.expWb)) begin
      reportMismatch("line writes", 256'(r.expWb), 256'(wrCount - wrBefore));
    end
    if (r.expWb) begin
      if (lastWrAddr !== r.wbAddr) reportMismatch("wrAddr_o", 256'(r.wbAddr), 256'(lastWrAddr));
      if (lastWrData !== shadowLine(r.wbAddr)) begin
        reportMismatch("wrData_o", shadowLine(r.wbAddr), lastWrData);
      end
    end
    if (r.op == OP_STORE) storeShadow(r.addr, r.data, r.mask);
  endtask

  initial begin
    errors    = 0;
    checks    = 0;
    expWrites = 0;
    rst_n     = 1'b0;
    reqValid  = 1'b0;
    req       = '0;
    buildTable();
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    checkIdle();
    for (int i = 0; i < NUM_ROWS; i++) begin
      runRow(i);
      expWrites += int'(stim[i].expWb);
    end
    if (wrCount != expWrites) reportMismatch("total line writes", 256'(expWrites), 256'(wrCount));
    $display("checks=%0d errors=%0d", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    repeat (NUM_ROWS * 200 + 100) @(posedge clk);
    $display("timeout: the cache stopped answering requests");
    $display("checks=%0d errors=%0d", checks, errors);
    $display("sim failed");
    $finish;
  end

endmodule

// File: bench/memModel.sv
`timescale 1ns/1ps

module memModel #(
  parameter dcachePkg::word_t PATTERN = 64'h0,
  parameter int unsigned      SEED    = 32'h393b_0a0c
) (
  input  logic             clk,
  input  logic             rdValid_i,
  input  dcachePkg::addr_t rdAddr_i,
  output logic             rdReady_o,
  output dcachePkg::word_t data_o,
  output logic             dataValid_o,
  output logic             last_o,
  input  logic             wrValid_i,
  input  dcachePkg::addr_t wrAddr_i,
  input  dcachePkg::line_t wrData_i,
  output logic             wrReady_o,
  output int               rdCount_o,
  output int               wrCount_o,
  output dcachePkg::addr_t lastWrAddr_o,
  output dcachePkg::line_t lastWrData_o
);
  import dcachePkg::*;

  // only written words are stored, the rest follow the fill rule
  word_t       mem [addr_t];
  int unsigned seedVal;

  function automatic word_t wordAt(addr_t a);
    if (mem.exists(a)) begin
      return mem[a];
    end
    return {a, a} ^ PATTERN;
  endfunction

  task automatic serveRead();
    addr_t base;
    base = rdAddr_i;
    rdCount_o++;
    repeat ($urandom % 4) @(negedge clk);
    rdReady_o = 1'b1;
    @(negedge clk);
    rdReady_o = 1'b0;
    for (int b = 0; b < WORDS_PER_LINE; b++) begin
      // occasional idle cycle between beats
      if ($urandom % 2 == 1) begin
        dataValid_o = 1'b0;
        @(negedge clk);
      end
      data_o      = wordAt(base + addr_t'(b * 8));
      dataValid_o = 1'b1;
      last_o      = (b == WORDS_PER_LINE - 1);
      @(negedge clk);
    end
    dataValid_o = 1'b0;
    last_o      = 1'b0;
  endtask

  task automatic serveWrite();
    repeat ($urandom % 4) @(negedge clk);
    wrReady_o    = 1'b1;
    wrCount_o++;
    lastWrAddr_o = wrAddr_i;
    lastWrData_o = wrData_i;
    for (int w = 0; w < WORDS_PER_LINE; w++) begin
      mem[wrAddr_i + addr_t'(w * 8)] = wrData_i[w];
    end
    @(negedge clk);
    wrReady_o = 1'b0;
  endtask

  initial begin
    seedVal      = $urandom(SEED);
    rdReady_o    = 1'b0;
    data_o       = '0;
    dataValid_o  = 1'b0;
    last_o       = 1'b0;
    wrReady_o    = 1'b0;
    rdCount_o    = 0;
    wrCount_o    = 0;
    lastWrAddr_o = '0;
    lastWrData_o = '0;
    // the cache never asks for a read and a write at once
    forever begin
      @(negedge clk);
      if (rdValid_i) begin
        serveRead();
      end else if (wrValid_i) begin
        serveWrite();
      end
    end
  end

endmodule

// File: common/dcachePkg.sv
package dcachePkg;

  // bus and line geometry
  localparam int ADDR_WIDTH     = 32;
  localparam int XLEN           = 64;
  localparam int WORDS_PER_LINE = 4;
  localparam int OFFSET_BITS    = 5;

  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [XLEN-1:0]       word_t;
  typedef logic [XLEN/8-1:0]     mask_t;

  // word 0 sits in the low 64 bits
  typedef word_t [WORDS_PER_LINE-1:0] line_t;

  typedef enum logic {
    OP_LOAD  = 1'b0,
    OP_STORE = 1'b1
  } cacheOp_e;

  typedef struct packed {
    cacheOp_e op;
    addr_t    addr;
    word_t    wdata;
    mask_t    wmask;
  } cacheReq_t;

  typedef enum logic [2:0] {
    S_IDLE       = 3'd0,
    S_LOOKUP     = 3'd1,
    S_WRITEBACK  = 3'd2,
    S_REFILL_REQ = 3'd3,
    S_REFILL     = 3'd4,
    S_INSTALL    = 3'd5,
    S_REPLAY     = 3'd6
  } ctrlState_e;

  // victimAddr is line aligned
  typedef struct packed {
    logic  hit;
    logic  hitWay;
    logic  victimWay;
    logic  victimDirty;
    addr_t victimAddr;
  } lookup_t;

endpackage

// File: dcache/dataStore.sv
`timescale 1ns/1ps

module dataStore #(
  parameter int SETS = 64
) (
  input  logic                 clk,
  input  dcachePkg::cacheReq_t req_i,
  input  dcachePkg::cacheReq_t latReq_i,
  input  logic                 dataRead_i,
  input  logic                 storeWrite_i,
  input  logic                 installWrite_i,
  input  logic                 wrWay_i,
  input  dcachePkg::line_t     refillLine_i,
  output dcachePkg::line_t     way0Line_o,
  output dcachePkg::line_t     way1Line_o
);
  import dcachePkg::*;

  localparam int IDX_BITS  = $clog2(SETS);
  localparam int LANE_BITS = $clog2(WORDS_PER_LINE);
  localparam int BYTES     = XLEN / 8;

  line_t                lineMem [2][SETS];
  line_t                wayQ [2];
  logic [IDX_BITS-1:0]  rdIdx;
  logic [IDX_BITS-1:0]  wrIdx;
  logic [LANE_BITS-1:0] lane;

  // reads index with the live request, writes with the latched one
  assign rdIdx = req_i.addr[OFFSET_BITS +: IDX_BITS];
  assign wrIdx = latReq_i.addr[OFFSET_BITS +: IDX_BITS];
  assign lane  = latReq_i.addr[OFFSET_BITS-1 -: LANE_BITS];

  always_ff @(posedge clk) begin
    if (installWrite_i) begin
      lineMem[wrWay_i][wrIdx] <= refillLine_i;
    end else if (storeWrite_i) begin
      // byte enables apply inside the addressed word lane
      for (int i = 0; i < BYTES; i++) begin
        if (latReq_i.wmask[i]) begin
          lineMem[wrWay_i][wrIdx][lane][i*8 +: 8] <= latReq_i.wdata[i*8 +: 8];
        end
      end
    end
  end

  // synchronous read port, holds between reads
  always_ff @(posedge clk) begin
    if (dataRead_i) begin
      wayQ[0] <= lineMem[0][rdIdx];
      wayQ[1] <= lineMem[1][rdIdx];
    end else if (installWrite_i) begin
      // installed line shows up on its way for the replayed lookup
      wayQ[wrWay_i] <= refillLine_i;
    end
  end

  assign way0Line_o = wayQ[0];
  assign way1Line_o = wayQ[1];

endmodule

// File: dcache/dcacheCtrl.sv
`timescale 1ns/1ps

module dcacheCtrl (
  input  logic                 clk,
  input  logic                 rst_n,
  input  dcachePkg::cacheReq_t req_i,
  input  logic                 reqValid_i,
  input  dcachePkg::lookup_t   lookup_i,
  input  logic                 refillDone_i,
  input  logic                 memRdReady_i,
  input  logic                 memWrReady_i,
  output dcachePkg::cacheReq_t latReq_o,
  output logic                 dataRead_o,
  output logic                 storeWrite_o,
  output logic                 installWrite_o,
  output logic                 wrWay_o,
  output logic                 refillActive_o,
  output logic                 addrOk_o,
  output logic                 respValid_o,
  output logic                 rdValid_o,
  output dcachePkg::addr_t     rdAddr_o,
  output logic                 wrValid_o,
  output dcachePkg::addr_t     wrAddr_o
);
  import dcachePkg::*;

  ctrlState_e state;
  ctrlState_e nextState;
  cacheReq_t  latReq;
  logic       accept;
  logic       lookupHit;

  assign accept    = (state == S_IDLE) && reqValid_i;
  assign lookupHit = (state == S_LOOKUP) && lookup_i.hit;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= S_IDLE;
    end else begin
      state <= nextState;
    end
  end

  // request held from acceptance until the response
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      latReq <= '0;
    end else if (accept) begin
      latReq <= req_i;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      S_IDLE: begin
        if (reqValid_i) begin
          nextState = S_LOOKUP;
        end
      end
      S_LOOKUP: begin
        if (lookup_i.hit) begin
          nextState = S_IDLE;
        end else if (lookup_i.victimDirty) begin
          nextState = S_WRITEBACK;
        end else begin
          nextState = S_REFILL_REQ;
        end
      end
      S_WRITEBACK: begin
        if (memWrReady_i) begin
          nextState = S_REFILL_REQ;
        end
      end
      S_REFILL_REQ: begin
        if (memRdReady_i) begin
          nextState = S_REFILL;
        end
      end
      S_REFILL: begin
        if (refillDone_i) begin
          nextState = S_INSTALL;
        end
      end
      // new line is written, then the request goes round again
      S_INSTALL: nextState = S_REPLAY;
      S_REPLAY:  nextState = S_LOOKUP;
      default:   nextState = S_IDLE;
    endcase
  end

  assign latReq_o       = latReq;
  assign addrOk_o       = (state == S_IDLE);
  assign dataRead_o     = accept;
  assign respValid_o    = lookupHit;
  assign storeWrite_o   = lookupHit && (latReq.op == OP_STORE);
  assign installWrite_o = (state == S_INSTALL);
  assign refillActive_o = (state == S_REFILL);
  // stores go to the hit way, installs to the victim
  assign wrWay_o        = (state == S_INSTALL) ? lookup_i.victimWay : lookup_i.hitWay;

  assign rdValid_o = (state == S_REFILL_REQ);
  assign rdAddr_o  = {latReq.addr[ADDR_WIDTH-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
  assign wrValid_o = (state == S_WRITEBACK);
  assign wrAddr_o  = lookup_i.victimAddr;

  // victim address holds while the write channel stalls
  wrReqHeld: assert property (@(posedge clk) disable iff (!rst_n)
    (wrValid_o && !memWrReady_i) |=> (wrValid_o && $stable(wrAddr_o)));

  // the replayed lookup finds the installed line
  replayHits: assert property (@(posedge clk) disable iff (!rst_n)
    (state == S_REPLAY) |=> respValid_o);

endmodule

// File: dcache/refillBuffer.sv
`timescale 1ns/1ps

module refillBuffer (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             refillActive_i,
  input  dcachePkg::word_t memData_i,
  input  logic             memDataValid_i,
  input  logic             memLast_i,
  output dcachePkg::line_t refillLine_o,
  output logic             refillDone_o
);
  import dcachePkg::*;

  localparam int CNT_BITS = $clog2(WORDS_PER_LINE);

  logic [CNT_BITS-1:0] beatCnt;
  line_t               lineBuf;
  logic                beatTake;

  assign beatTake = refillActive_i && memDataValid_i;

  // counter wraps back to zero after the fourth beat
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beatCnt <= '0;
    end else if (beatTake) begin
      beatCnt <= beatCnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (beatTake) begin
      lineBuf[beatCnt] <= memData_i;
    end
  end

  assign refillLine_o = lineBuf;
  assign refillDone_o = beatTake && memLast_i;

  lastOnFinalBeat: assert property (@(posedge clk) disable iff (!rst_n)
    (beatTake && memLast_i) |-> (beatCnt == CNT_BITS'(WORDS_PER_LINE - 1)));

endmodule

// File: dcache/tagStore.sv
`timescale 1ns/1ps

module tagStore #(
  parameter int SETS = 64
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  dcachePkg::cacheReq_t latReq_i,
  input  logic                 storeWrite_i,
  input  logic                 installWrite_i,
  input  logic                 wrWay_i,
  output dcachePkg::lookup_t   lookup_o
);
  import dcachePkg::*;

  localparam int IDX_BITS = $clog2(SETS);
  localparam int TAG_BITS = ADDR_WIDTH - OFFSET_BITS - IDX_BITS;

  logic [TAG_BITS-1:0] tagArr [2][SETS];
  logic [SETS-1:0]     validArr [2];
  logic [SETS-1:0]     dirtyArr [2];
  logic [SETS-1:0]     rrBit;
  logic [IDX_BITS-1:0] idx;
  logic [TAG_BITS-1:0] tag;
  logic [1:0]          wayHit;
  logic                victim;

  assign idx = latReq_i.addr[OFFSET_BITS +: IDX_BITS];
  assign tag = latReq_i.addr[ADDR_WIDTH-1 -: TAG_BITS];

  assign wayHit[0] = validArr[0][idx] && (tagArr[0][idx] == tag);
  assign wayHit[1] = validArr[1][idx] && (tagArr[1][idx] == tag);

  // empty way first, then round robin
  always_comb begin
    if (!validArr[0][idx]) begin
      victim = 1'b0;
    end else if (!validArr[1][idx]) begin
      victim = 1'b1;
    end else begin
      victim = rrBit[idx];
    end
  end

  always_comb begin
    lookup_o.hit         = |wayHit;
    lookup_o.hitWay      = wayHit[1];
    lookup_o.victimWay   = victim;
    lookup_o.victimDirty = validArr[victim][idx] && dirtyArr[victim][idx];
    lookup_o.victimAddr  = {tagArr[victim][idx], idx, {OFFSET_BITS{1'b0}}};
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validArr[0] <= '0;
      validArr[1] <= '0;
      dirtyArr[0] <= '0;
      dirtyArr[1] <= '0;
      rrBit       <= '0;
    end else if (installWrite_i) begin
      validArr[wrWay_i][idx] <= 1'b1;
      dirtyArr[wrWay_i][idx] <= 1'b0;
      rrBit[idx]             <= ~rrBit[idx];
    end else if (storeWrite_i) begin
      dirtyArr[wrWay_i][idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (installWrite_i) begin
      tagArr[wrWay_i][idx] <= tag;
    end
  end

  // a line lives in one way only
  singleWayHit: assert property (@(posedge clk) disable iff (!rst_n) !(&wayHit));

endmodule

// File: design/dcacheTop.sv
`timescale 1ns/1ps

module dcacheTop #(
  parameter int SETS = 64
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  dcachePkg::cacheReq_t req_i,
  input  logic                 reqValid_i,
  output logic                 addrOk_o,
  output logic                 respValid_o,
  output dcachePkg::word_t     rdData_o,
  output logic                 rdValid_o,
  output dcachePkg::addr_t     rdAddr_o,
  input  logic                 memRdReady_i,
  input  dcachePkg::word_t     memData_i,
  input  logic                 memDataValid_i,
  input  logic                 memLast_i,
  output logic                 wrValid_o,
  output dcachePkg::addr_t     wrAddr_o,
  output dcachePkg::line_t     wrData_o,
  input  logic                 memWrReady_i
);
  import dcachePkg::*;

  cacheReq_t latReq;
  lookup_t   lookup;
  line_t     way0Line;
  line_t     way1Line;
  line_t     refillLine;
  line_t     hitLine;
  logic      dataRead;
  logic      storeWrite;
  logic      installWrite;
  logic      wrWay;
  logic      refillActive;
  logic      refillDone;

  dcacheCtrl uCtrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_i         (req_i),
    .reqValid_i    (reqValid_i),
    .lookup_i      (lookup),
    .refillDone_i  (refillDone),
    .memRdReady_i  (memRdReady_i),
    .memWrReady_i  (memWrReady_i),
    .latReq_o      (latReq),
    .dataRead_o    (dataRead),
    .storeWrite_o  (storeWrite),
    .installWrite_o(installWrite),
    .wrWay_o       (wrWay),
    .refillActive_o(refillActive),
    .addrOk_o      (addrOk_o),
    .respValid_o   (respValid_o),
    .rdValid_o     (rdValid_o),
    .rdAddr_o      (rdAddr_o),
    .wrValid_o     (wrValid_o),
    .wrAddr_o      (wrAddr_o)
  );

  tagStore #(.SETS(SETS)) uTags (
    .clk           (clk),
    .rst_n         (rst_n),
    .latReq_i      (latReq),
    .storeWrite_i  (storeWrite),
    .installWrite_i(installWrite),
    .wrWay_i       (wrWay),
    .lookup_o      (lookup)
  );

  dataStore #(.SETS(SETS)) uData (
    .clk           (clk),
    .req_i         (req_i),
    .latReq_i      (latReq),
    .dataRead_i    (dataRead),
    .storeWrite_i  (storeWrite),
    .installWrite_i(installWrite),
    .wrWay_i       (wrWay),
    .refillLine_i  (refillLine),
    .way0Line_o    (way0Line),
    .way1Line_o    (way1Line)
  );

  refillBuffer uRefill (
    .clk           (clk),
    .rst_n         (rst_n),
    .refillActive_i(refillActive),
    .memData_i     (memData_i),
    .memDataValid_i(memDataValid_i),
    .memLast_i     (memLast_i),
    .refillLine_o  (refillLine),
    .refillDone_o  (refillDone)
  );

  // load word comes from the hit way, picked by address bits 4..3
  assign hitLine  = lookup.hitWay ? way1Line : way0Line;
  assign rdData_o = hitLine[latReq.addr[OFFSET_BITS-1 -: 2]];

  // victim line stays on the read port through write-back
  assign wrData_o = lookup.victimWay ? way1Line : way0Line;

endmodule

// File: run.sh
#!/usr/bin/env bash
# builds with Verilator and decides pass or fail from the simulation output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module dcacheTb -f src.f -o simv &&
./obj_dir/simv | tee /dev/stderr | grep -qx "sim passed" &&
echo "run ok" ||
{ echo "run not ok"; exit 1; }

// File: src.f
common/dcachePkg.sv
dcache/dcacheCtrl.sv
dcache/tagStore.sv
dcache/dataStore.sv
dcache/refillBuffer.sv
design/dcacheTop.sv
bench/memModel.sv
bench/dcacheTb.sv
